// ==== all.f ====
+incdir+common
common/soc_pkg.sv
hw/bus_decoder.sv
hw/leds_wb8.sv
timer/timer_wb8.sv
prng/prng_wb8.sv
hw/ram_wb8.sv
hw/soc_bus_top.sv
sim/bus_checker.sv
sim/tb_soc_bus_top.sv

// ==== common/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// upper 24 address bits of the 256 byte peripheral windows
`define SOC_LEDS_BASE 24'hFFFFFF
`define SOC_PRNG_BASE 24'hFFFFFE
`define SOC_TIMER_BASE 24'hFFFFFD

// scratch RAM, 1024 bytes, aliased over the default region
`define SOC_RAM_ADDR_BITS 10

// galois feedback mask, right shifting form
`define SOC_PRNG_TAPS 32'h80200003

// clocks per timer tick
`define SOC_TIMER_PRESCALE 4

`endif

// ==== common/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

    // request from the single bus master
    typedef struct packed {
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [7:0]  dat;
    } wb8_req_t;

    // answer from one slave
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb8_rsp_t;

    // timer control byte, bit 0 is enable
    typedef struct packed {
        logic [4:0] reserved;
        logic       pending;
        logic       irq_enable;
        logic       enable;
    } timer_ctrl_t;

    // raw byte for the bus, fields for the timer logic
    typedef union packed {
        logic [7:0]  raw;
        timer_ctrl_t f;
    } timer_ctrl_u;

endpackage

`default_nettype wire

// ==== hw/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module bus_decoder import soc_pkg::*; (
    input  wb8_req_t bus_req_i,
    output logic     leds_stb_o,
    output logic     prng_stb_o,
    output logic     timer_stb_o,
    output logic     ram_stb_o,
    input  wb8_rsp_t leds_rsp_i,
    input  wb8_rsp_t prng_rsp_i,
    input  wb8_rsp_t timer_rsp_i,
    input  wb8_rsp_t ram_rsp_i,
    output wb8_rsp_t bus_rsp_o
);

    logic [23:0] page;

    assign page = bus_req_i.adr[31:8];

    // one window per peripheral, everything else lands in RAM
    always_comb begin
        leds_stb_o  = 1'b0;
        prng_stb_o  = 1'b0;
        timer_stb_o = 1'b0;
        ram_stb_o   = 1'b0;
        bus_rsp_o   = ram_rsp_i;

        case (page)
            `SOC_LEDS_BASE: begin
                leds_stb_o = bus_req_i.stb;
                bus_rsp_o  = leds_rsp_i;
            end

            `SOC_PRNG_BASE: begin
                prng_stb_o = bus_req_i.stb;
                bus_rsp_o  = prng_rsp_i;
            end

            `SOC_TIMER_BASE: begin
                timer_stb_o = bus_req_i.stb;
                bus_rsp_o   = timer_rsp_i;
            end

            // boot ROM, reserved pages and unmapped space
            default: begin
                ram_stb_o = bus_req_i.stb;
                bus_rsp_o = ram_rsp_i;
            end
        endcase
    end

    // never more than one slave answering at a time
    a_ack_onehot: assert final (
        $onehot0({leds_rsp_i.ack, prng_rsp_i.ack, timer_rsp_i.ack, ram_rsp_i.ack})
    ) else begin
        $error("more than one slave acknowledge active");
    end

endmodule

`default_nettype wire

// ==== hw/leds_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

module leds_wb8 import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       stb_i,
    input  wb8_req_t   req_i,
    output wb8_rsp_t   rsp_o,
    output logic [7:0] leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;
    logic       access;

    // new access only while the previous ack is not pending
    assign access = stb_i && !ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            leds_q <= 8'h00;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    // whole window reads back the register
    assign rsp_o.dat = leds_q;
    assign rsp_o.ack = ack_q;

    assign leds_o = leds_q;

endmodule

`default_nettype wire

// ==== hw/ram_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module ram_wb8 import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  wb8_req_t req_i,
    output wb8_rsp_t rsp_o
);

    localparam int DEPTH = 1 << `SOC_RAM_ADDR_BITS;

    logic [7:0]                   mem [0:DEPTH-1];
    logic [`SOC_RAM_ADDR_BITS-1:0] addr;
    logic [7:0]                   rdata_q;
    logic                         ack_q;
    logic                         access;

    // upper address bits ignored, so the array aliases
    assign addr   = req_i.adr[`SOC_RAM_ADDR_BITS-1:0];
    assign access = stb_i && !ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                mem[addr] <= req_i.dat;
            end
            rdata_q <= mem[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

// ==== hw/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  wb8_req_t   bus_req_i,
    output wb8_rsp_t   bus_rsp_o,
    output logic [7:0] leds_o,
    output logic       timer_irq_o
);

    logic     leds_stb;
    logic     prng_stb;
    logic     timer_stb;
    logic     ram_stb;
    wb8_rsp_t leds_rsp;
    wb8_rsp_t prng_rsp;
    wb8_rsp_t timer_rsp;
    wb8_rsp_t ram_rsp;

    bus_decoder i_bus_decoder (
        .bus_req_i   (bus_req_i),
        .leds_stb_o  (leds_stb),
        .prng_stb_o  (prng_stb),
        .timer_stb_o (timer_stb),
        .ram_stb_o   (ram_stb),
        .leds_rsp_i  (leds_rsp),
        .prng_rsp_i  (prng_rsp),
        .timer_rsp_i (timer_rsp),
        .ram_rsp_i   (ram_rsp),
        .bus_rsp_o   (bus_rsp_o)
    );

    leds_wb8 i_leds_wb8 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (leds_stb),
        .req_i   (bus_req_i),
        .rsp_o   (leds_rsp),
        .leds_o  (leds_o)
    );

    timer_wb8 i_timer_wb8 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (timer_stb),
        .req_i   (bus_req_i),
        .rsp_o   (timer_rsp),
        .irq_o   (timer_irq_o)
    );

    prng_wb8 i_prng_wb8 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (prng_stb),
        .req_i   (bus_req_i),
        .rsp_o   (prng_rsp)
    );

    // default region
    ram_wb8 i_ram_wb8 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (ram_stb),
        .req_i   (bus_req_i),
        .rsp_o   (ram_rsp)
    );

endmodule

`default_nettype wire

// ==== prng/prng_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module prng_wb8 import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  wb8_req_t req_i,
    output wb8_rsp_t rsp_o
);

    logic [31:0] state_q;
    logic [31:0] state_step;
    logic [31:0] state_load;
    logic [4:0]  bit_base;
    logic [7:0]  rdata_q;
    logic        ack_q;
    logic        access;

    assign access   = stb_i && !ack_q;
    assign bit_base = {req_i.adr[1:0], 3'b000};

    // galois step, shift right and fold in the taps
    assign state_step = {1'b0, state_q[31:1]} ^ (state_q[0] ? `SOC_PRNG_TAPS : 32'h0);

    always_comb begin
        state_load = state_q;
        state_load[bit_base +: 8] = req_i.dat;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= 32'd1;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                // an all-zero state would lock up the LFSR
                state_q <= (state_load == 32'd0) ? 32'd1 : state_load;
            end else if (access && req_i.adr[1:0] == 2'd0) begin
                state_q <= state_step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= state_q[bit_base +: 8];
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

    a_state_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        state_q != 32'd0);

endmodule

`default_nettype wire

// ==== sim/bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_checker import soc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  wb8_req_t   bus_req_i,
    input  wb8_rsp_t   bus_rsp_i,
    input  logic [7:0] leds_i,
    input  logic       timer_irq_i,
    input  logic [7:0] exp_dat_i,
    input  logic       exp_chk_i,
    input  logic [7:0] exp_leds_i,
    input  logic       exp_irq_i,
    input  logic       irq_chk_i,
    output int         ack_errors_o,
    output int         data_errors_o,
    output int         out_errors_o
);

    logic busy;
    int   age;

    initial begin
        ack_errors_o  = 0;
        data_errors_o = 0;
        out_errors_o  = 0;
    end

    // all inputs change on the falling edge, so the rising edge sees them settled
    always @(posedge clk) begin
        if (!rst_n_i) begin
            busy = 1'b0;
            age  = 0;
        end else begin
            if (busy) begin
                age = age + 1;
            end

            if (bus_rsp_i.ack === 1'b1) begin
                if (!busy) begin
                    ack_errors_o++;
                    $display("acknowledge seen with no access in progress at %0t", $time);
                end else if (age != 1) begin
                    ack_errors_o++;
                    $display("acknowledge came %0d cycles after the strobe instead of 1", age);
                end
                if (exp_chk_i && bus_rsp_i.dat !== exp_dat_i) begin
                    data_errors_o++;
                    $display("ERR bus_rsp_o.dat got %h expected %h at address %h",
                             bus_rsp_i.dat, exp_dat_i, bus_req_i.adr);
                end
                busy = 1'b0;
            end else if (busy && age >= 1) begin
                ack_errors_o++;
                $display("no acknowledge one cycle after the strobe at address %h",
                         bus_req_i.adr);
                busy = 1'b0;
            end else if (!busy && bus_req_i.stb) begin
                busy = 1'b1;
                age  = 0;
            end

            if (leds_i !== exp_leds_i) begin
                out_errors_o++;
                $display("ERR leds_o got %h expected %h", leds_i, exp_leds_i);
            end
            // irq is left unchecked while its rise time is open
            if (irq_chk_i && timer_irq_i !== exp_irq_i) begin
                out_errors_o++;
                $display("ERR timer_irq_o got %h expected %h", timer_irq_i, exp_irq_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module tb_soc_bus_top import soc_pkg::*; ();

    localparam int          ACK_TIMEOUT = 8;
    localparam logic [31:0] STIM_TAPS   = 32'hB4BCD35C;
    localparam int          REG_LEDS    = 0;
    localparam int          REG_PRNG    = 1;
    localparam int          REG_TIMER   = 2;
    localparam int          REG_RAM     = 3;
    localparam int          RAM_DEPTH   = 1 << `SOC_RAM_ADDR_BITS;

    logic        clk = 1'b0;
    logic        rst_n;
    wb8_req_t    bus_req;
    wb8_rsp_t    bus_rsp;
    logic [7:0]  leds;
    logic        timer_irq;
    logic [7:0]  exp_dat;
    logic        exp_chk;
    logic [7:0]  exp_leds;
    logic        exp_irq;
    logic        irq_chk;
    int          ack_errors;
    int          data_errors;
    int          out_errors;
    int          timeouts = 0;
    logic [31:0] stim_state;
    logic [31:0] prng_model;
    logic [7:0]  ram_shadow [0:RAM_DEPTH-1];
    bit          ram_valid [0:RAM_DEPTH-1];

    always #20 clk = ~clk;

    soc_bus_top i_soc_bus_top (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .bus_req_i   (bus_req),
        .bus_rsp_o   (bus_rsp),
        .leds_o      (leds),
        .timer_irq_o (timer_irq)
    );

    bus_checker i_bus_checker (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .bus_req_i     (bus_req),
        .bus_rsp_i     (bus_rsp),
        .leds_i        (leds),
        .timer_irq_i   (timer_irq),
        .exp_dat_i     (exp_dat),
        .exp_chk_i     (exp_chk),
        .exp_leds_i    (exp_leds),
        .exp_irq_i     (exp_irq),
        .irq_chk_i     (irq_chk),
        .ack_errors_o  (ack_errors),
        .data_errors_o (data_errors),
        .out_errors_o  (out_errors)
    );

    // stimulus source, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            stim_state = {1'b0, stim_state[31:1]} ^ (stim_state[0] ? STIM_TAPS : 32'h0);
            r = {r[30:0], stim_state[0]};
        end
        return r;
    endfunction

    function automatic int region_of(input logic [31:0] adr);
        case (adr[31:8])
            `SOC_LEDS_BASE:  return REG_LEDS;
            `SOC_PRNG_BASE:  return REG_PRNG;
            `SOC_TIMER_BASE: return REG_TIMER;
            default:         return REG_RAM;
        endcase
    endfunction

    // expected PRNG state after one read at offset 0
    function automatic logic [31:0] prng_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? `SOC_PRNG_TAPS : 32'h0);
    endfunction

    task automatic bus_access(input logic [31:0] adr, input logic we, input logic [7:0] wdat,
                              input logic chk, input logic [7:0] exp);
        int n;
        @(negedge clk);
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.adr = adr;
        bus_req.dat = wdat;
        exp_chk     = chk;
        exp_dat     = exp;
        n = 0;
        while (bus_rsp.ack !== 1'b1 && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        // expectation stays posted until the checker has seen the acknowledge
        bus_req.stb = 1'b0;
        if (bus_rsp.ack !== 1'b1) begin
            timeouts++;
            $display("no acknowledge for the access to address %h", adr);
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [7:0] dat);
        bus_access(adr, 1'b1, dat, 1'b0, 8'h00);
    endtask

    task automatic bus_read(input logic [31:0] adr, input logic [7:0] exp);
        bus_access(adr, 1'b0, 8'h00, 1'b1, exp);
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (timer_irq !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (timer_irq !== 1'b1) begin
            timeouts++;
            $display("timer interrupt did not rise within %0d cycles", limit);
        end
    endtask

    initial begin
        logic [31:0]                   adr;
        logic [`SOC_RAM_ADDR_BITS-1:0] idx;
        logic [7:0]                    d;
        logic [7:0]                    off;
        logic [7:0]                    reload;
        stim_state = 32'hec75bb81;
        bus_req    = '0;
        rst_n      = 1'b0;
        exp_dat    = 8'h00;
        exp_chk    = 1'b0;
        exp_leds   = 8'h00;
        exp_irq    = 1'b0;
        irq_chk    = 1'b1;
        prng_model = 32'd1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        bus_read({`SOC_PRNG_BASE, 8'h01}, prng_model[15:8]);

        // few distinct locations so reads hit earlier writes through the aliases
        for (int i = 0; i < 64; i++) begin
            adr = rand_bits(32);
            case (rand_bits(2))
                0:       adr[31:8] = 24'h000000;
                1:       adr[31:8] = 24'hFFFFFC;
                default: ;
            endcase
            adr[9:6] = 4'(rand_bits(4));
            adr[5:0] = 6'h2d;
            if (region_of(adr) != REG_RAM) begin
                adr[31] = 1'b0;
            end
            idx = adr[`SOC_RAM_ADDR_BITS-1:0];
            if (rand_bits(1) || !ram_valid[idx]) begin
                d = 8'(rand_bits(8));
                bus_write(adr, d);
                ram_shadow[idx] = d;
                ram_valid[idx]  = 1'b1;
            end else begin
                bus_read(adr, ram_shadow[idx]);
            end
        end

        d   = 8'(rand_bits(8));
        off = 8'(rand_bits(8));
        bus_write({`SOC_LEDS_BASE, off}, d);
        exp_leds = d;
        repeat (3) begin
            off = 8'(rand_bits(8));
            bus_read({`SOC_LEDS_BASE, off}, d);
        end

        for (int b = 0; b < 4; b++) begin
            d = 8'(rand_bits(8));
            bus_write({`SOC_PRNG_BASE, 8'(b)}, d);
            prng_model[b*8 +: 8] = d;
            if (prng_model == 32'd0) begin
                prng_model = 32'd1;
            end
        end
        repeat (8) begin
            bus_read({`SOC_PRNG_BASE, 8'h00}, prng_model[7:0]);
            prng_model = prng_next(prng_model);
        end

        reload = 8'(rand_bits(3)) + 8'd2;
        bus_write({`SOC_TIMER_BASE, 8'h01}, reload);
        bus_write({`SOC_TIMER_BASE, 8'h02}, 8'h00);
        irq_chk = 1'b0;
        bus_write({`SOC_TIMER_BASE, 8'h00}, 8'h03);
        wait_irq(int'(reload) * `SOC_TIMER_PRESCALE + 16);
        // stop first so no new wrap races the clear
        bus_write({`SOC_TIMER_BASE, 8'h00}, 8'h02);
        bus_write({`SOC_TIMER_BASE, 8'h00}, 8'h06);
        exp_irq = 1'b0;
        irq_chk = 1'b1;
        bus_read({`SOC_TIMER_BASE, 8'h00}, 8'h02);
        bus_write({`SOC_TIMER_BASE, 8'h00}, 8'h01);
        repeat (2 * int'(reload) * `SOC_TIMER_PRESCALE + 16) @(negedge clk);
        bus_read({`SOC_TIMER_BASE, 8'h00}, 8'h05);

        repeat (4) @(negedge clk);
        $display("errors: ack %0d, data %0d, outputs %0d, timeouts %0d",
                 ack_errors, data_errors, out_errors, timeouts);
        if (ack_errors + data_errors + out_errors + timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== timer/timer_wb8.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_defines.svh"

module timer_wb8 import soc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stb_i,
    input  wb8_req_t req_i,
    output wb8_rsp_t rsp_o,
    output logic     irq_o
);

    localparam int PRESC_MAX = `SOC_TIMER_PRESCALE - 1;
    localparam int PRESC_W   = $clog2(`SOC_TIMER_PRESCALE + 1);

    timer_ctrl_u        ctrl_q;
    timer_ctrl_u        wdata;
    logic [15:0]        reload_q;
    logic [15:0]        count_q;
    logic [PRESC_W-1:0] presc_q;
    logic [7:0]         rdata_q;
    logic               ack_q;
    logic               access;
    logic               wr;
    logic               tick;
    logic               wrap;

    assign wdata.raw = req_i.dat;

    assign access = stb_i && !ack_q;
    assign wr     = access && req_i.we;

    // one tick every prescale clocks while enabled
    assign tick = ctrl_q.f.enable && (presc_q == PRESC_W'(PRESC_MAX));
    // reload when leaving 1 or sitting at 0
    assign wrap = tick && (count_q <= 16'd1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ctrl_q   <= '0;
            reload_q <= 16'h0000;
            count_q  <= 16'h0000;
            presc_q  <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= access;

            if (!ctrl_q.f.enable || tick) begin
                presc_q <= '0;
            end else begin
                presc_q <= presc_q + 1'b1;
            end

            if (wr && req_i.adr[1:0] == 2'd1) begin
                reload_q[7:0] <= req_i.dat;
            end
            if (wr && req_i.adr[1:0] == 2'd2) begin
                reload_q[15:8] <= req_i.dat;
            end

            // high byte write restarts the count from the new reload
            if (wr && req_i.adr[1:0] == 2'd2) begin
                count_q <= {req_i.dat, reload_q[7:0]};
            end else if (wrap) begin
                count_q <= reload_q;
            end else if (tick) begin
                count_q <= count_q - 1'b1;
            end

            if (wr && req_i.adr[1:0] == 2'd0) begin
                ctrl_q.f.enable     <= wdata.f.enable;
                ctrl_q.f.irq_enable <= wdata.f.irq_enable;
            end

            // a new wrap wins over a clear in the same cycle
            if (wrap) begin
                ctrl_q.f.pending <= 1'b1;
            end else if (wr && req_i.adr[1:0] == 2'd0 && wdata.f.pending) begin
                ctrl_q.f.pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (req_i.adr[1:0])
                2'd0:    rdata_q <= ctrl_q.raw;
                2'd1:    rdata_q <= reload_q[7:0];
                2'd2:    rdata_q <= reload_q[15:8];
                default: rdata_q <= count_q[7:0];
            endcase
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;

    assign irq_o = ctrl_q.f.pending && ctrl_q.f.irq_enable;

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_o.ack |=> !rsp_o.ack);

    // pending can only be raised by a running counter
    a_pending_enabled: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(ctrl_q.f.pending) |-> $past(ctrl_q.f.enable));

endmodule

`default_nettype wire
